//--- testbench/rv_core_stimulus.txt
// Words 0..127 are the memory image (program at 0x000, data at 0x180)
// From word 128 on, triples of test id, store address, store data; ffffffff ends
@000
00500093 FFD00113 002081B3 10302023 40208233 10402223 0020F2B3 10502423
0020E333 10602623 0020C3B3 10702823 00112433 10802A23 123454B7 10902C23
18002503 00750593 10B02E23
00108463 1E002823 00109463 05500613 12C02023 00209463 1E002A23 00208463
008006EF 1E002C23 12D02223
12102423 12202623 18402703 12E02823 0000006F
@060
00000064 A5A50000
@080
00000000 00000100 00000002  00000000 00000104 00000008
00000000 00000108 00000005  00000000 0000010C FFFFFFFD
00000000 00000110 FFFFFFF8  00000000 00000114 00000001
00000000 00000118 12345000
00000001 0000011C 0000006B
00000002 00000120 00000055  00000002 00000124 00000070
00000003 00000128 00000005  00000003 0000012C FFFFFFFD
00000003 00000130 A5A50000
FFFFFFFF
@FF
FFFFFFFF

//--- rv_core.f
+incdir+hw
hw/rv_core_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/result_unit.sv
hw/cache_port_arbiter.sv
hw/rv_core.sv
testbench/tb_clock_gen.sv
testbench/rv_core_sva.sv
testbench/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -f rv_core.f -o rv_core_sim

output=$(./obj_dir/rv_core_sim)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_core_tb;

	logic        clk, nrst;
	logic        mem_req, mem_req_ack, mem_resp;
	logic [4:0]  mem_rqtype;
	logic [2:0]  mem_size;
	logic [31:0] mem_addr, mem_wdata, mem_resp_data;

	logic [31:0] stim [0:255];       // Image in 0..127, expected stores from 128
	logic [31:0] mem [0:127];
	int          exp_test[$];
	logic [31:0] exp_addr[$], exp_data[$];
	string       test_names [0:3] = '{"arith", "loads", "control", "arbitration"};
	int          test_err [0:3];
	int          errors = 0, tests_run = 0, tests_failed = 0, n_exp = 0;
	int          reset_err = 0;      // Reset behaviour failures
	logic        all_done = 1'b0, timed_out = 1'b0, first_req = 1'b1;

	tb_clock_gen u_clk (.clk(clk), .nrst(nrst));

	rv_core DUT (.*);

	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finish_test(input int t);
		tests_run++;
		if (test_err[t] != 0)
			tests_failed++;
		$display("%s: %s", test_names[t], test_err[t] == 0 ? "PASS" : "FAIL");
	endtask

	// Store checked against the head of the expected queue
	task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
		int t;
		if (exp_test.size() == 0)
		begin
			$display("Unexpected store of %h to %h after all expected stores", data, addr);
			errors++;
			return;
		end
		t = exp_test.pop_front();
		if (addr != exp_addr[0])
		begin
			$display("FAIL %s: store address expected %h actual %h",
				test_names[t], exp_addr[0], addr);
			test_err[t]++;
			errors++;
		end
		if (data != exp_data[0])
		begin
			$display("FAIL %s: store data expected %h actual %h",
				test_names[t], exp_data[0], data);
			test_err[t]++;
			errors++;
		end
		void'(exp_addr.pop_front());
		void'(exp_data.pop_front());
		if (exp_test.size() == 0 || exp_test[0] != t)
			finish_test(t);  // Last store of this test
		if (exp_test.size() == 0)
			all_done = 1'b1;
	endtask

	// Memory model, one request at a time
	initial
	begin
		logic [4:0]  rq;
		logic [31:0] addr, wd, rdata;
		void'($urandom(32'hdacaf958));  // One seed for all random delays
		mem_req_ack   = 1'b0;
		mem_resp      = 1'b0;
		mem_resp_data = '0;
		while (nrst !== 1'b1)
		begin
			@(negedge clk);
			if (!nrst && mem_req)
			begin
				$display("mem_req high during reset");
				reset_err++;
				errors++;
			end
		end
		forever
		begin
			@(posedge clk);
			#1;
			if (mem_req)
			begin
				rq    = mem_rqtype;
				addr  = mem_addr;
				wd    = mem_wdata;
				rdata = '0;
				if (first_req)
				begin
					first_req = 1'b0;
					tests_run++;
					if (rq != `RQ_IFILL || addr != `RV_RESET_PC)
					begin
						$display("FAIL reset: first request expected %h/%h actual %h/%h",
							`RQ_IFILL, `RV_RESET_PC, rq, addr);
						reset_err++;
						errors++;
					end
					if (reset_err != 0)
					begin
						tests_failed++;
						$display("reset: FAIL");
					end
					else
						$display("reset: PASS");
				end
				if (mem_size != 3'd2)
				begin
					$display("Request with size %0d, only words allowed", mem_size);
					errors++;
				end
				wait_cycles($urandom % 4);
				mem_req_ack = 1'b1;
				wait_cycles(1);
				mem_req_ack = 1'b0;
				if (rq == `RQ_IFILL)
				begin
					if (addr >= 32'h100 || addr[1:0] != 2'b00)
					begin
						$display("Fetch from %h, outside the program", addr);
						errors++;
					end
					else
						rdata = mem[addr[8:2]];
				end
				else if (rq == `RQ_LOAD)
					rdata = mem[addr[8:2]];
				else if (rq == `RQ_STORE)
				begin
					check_store(addr, wd);
					mem[addr[8:2]] = wd;
				end
				else
				begin
					$display("Request with unknown type %h at %h", rq, addr);
					errors++;
				end
				wait_cycles($urandom % 4);  // Response at least a cycle after ack
				mem_resp      = 1'b1;
				mem_resp_data = rdata;
				wait_cycles(1);
				mem_resp      = 1'b0;
			end
		end
	end

	initial
	begin
		int i;
		$readmemh("testbench/rv_core_stimulus.txt", stim);
		for (i = 0; i < 128; i++)
			mem[i] = stim[i];
		for (i = 128; i < 254 && stim[i] != 32'hffff_ffff; i += 3)
		begin
			exp_test.push_back(int'(stim[i]));  // Test id, address, data
			exp_addr.push_back(stim[i+1]);
			exp_data.push_back(stim[i+2]);
			n_exp++;
		end
		fork
			wait (all_done);
			begin
				repeat (200 * n_exp) @(posedge clk);  // Watchdog
				timed_out = 1'b1;
			end
		join_any
		disable fork;
		if (timed_out)
		begin
			$display("Timeout with %0d expected stores still missing", exp_test.size());
			errors++;
		end
		else
			repeat (50) @(posedge clk);  // Catch stray stores after the last one
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/rv_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva import rv_core_pkg::*; (
	input wire        clk,
	input wire        nrst,
	input arb_state_e state,
	input wire        fetch_out,
	input wire        mem_req,
	input wire        mem_req_ack,
	input wire        mem_resp,
	input wire  [4:0] mem_rqtype,
	input wire [31:0] mem_addr
);

	// Request and its fields hold until acked
	req_stable: assert property (@(posedge clk) disable iff (!nrst)
		mem_req && !mem_req_ack |=> mem_req && $stable(mem_addr) && $stable(mem_rqtype))
		else $error("port request changed before ack");

	ack_needs_req: assert property (@(posedge clk) disable iff (!nrst) mem_req_ack |-> mem_req)
		else $error("ack without request");

	// Response outside ARB_MEM must belong to an acked fetch
	resp_is_fetch: assert property (@(posedge clk) disable iff (!nrst)
		mem_resp && state != ARB_MEM |-> fetch_out)
		else $error("response with no fetch outstanding");

	// Nothing new on the port while a fetch response is due
	one_outstanding: assert property (@(posedge clk) disable iff (!nrst)
		mem_req |-> !fetch_out)
		else $error("request while a fetch response is still due");

endmodule

bind cache_port_arbiter rv_core_sva u_sva (.*);

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	initial
	begin
		nrst = 1'b0;
		repeat (2) @(posedge clk);
		#1 nrst = 1'b1;  // Released just after the second edge
	end

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module rv_core import rv_core_pkg::*; (
	input  wire                 clk,
	input  wire                 nrst,
	output logic                mem_req,
	output logic [4:0]          mem_rqtype,
	output logic [2:0]          mem_size,
	output logic [`RV_XLEN-1:0] mem_addr,
	output logic [`RV_XLEN-1:0] mem_wdata,
	input  wire                 mem_req_ack,
	input  wire                 mem_resp,
	input  wire  [`RV_XLEN-1:0] mem_resp_data
);

	// Fetch side of the port
	logic                fetch_req, fetch_ack, fetch_resp;
	logic [`RV_XLEN-1:0] fetch_addr, fetch_rdata;
	// Fetch to decode
	logic                fetch_valid, fetch_take;
	logic [`RV_XLEN-1:0] instr, instr_pc;
	// Register file reads
	logic [4:0]          rs1_addr, rs2_addr;
	logic [`RV_XLEN-1:0] rs1_data, rs2_data;
	// Issue bundle
	logic                issue_valid, rd_we, is_branch, branch_ne, is_jal;
	logic [`RV_XLEN-1:0] op_a, op_b, imm, issue_pc;
	logic [4:0]          rd;
	alu_op_e             alu_op;
	mem_op_e             mem_op;
	// Execute results
	logic                exec_busy, redirect, wb_en;
	logic [`RV_XLEN-1:0] redirect_pc, wb_data;
	logic [4:0]          wb_rd;
	// Data side of the port
	logic                data_req, data_ack, data_resp;
	logic [4:0]          data_rqtype;
	logic [`RV_XLEN-1:0] data_addr, data_wdata, data_rdata;

	fetch_unit u_fetch (.*);

	decode_unit u_decode (.*);

	execute_unit u_execute (.*);

	result_unit u_result (.*);

	cache_port_arbiter u_arbiter (.*);

endmodule

`default_nettype wire

//--- hw/cache_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module cache_port_arbiter import rv_core_pkg::*; (
	input  wire                 clk,
	input  wire                 nrst,
	input  wire                 fetch_req,
	input  wire  [`RV_XLEN-1:0] fetch_addr,
	output logic                fetch_ack,
	output logic                fetch_resp,
	output logic [`RV_XLEN-1:0] fetch_rdata,
	input  wire                 data_req,
	input  wire  [4:0]          data_rqtype,
	input  wire  [`RV_XLEN-1:0] data_addr,
	input  wire  [`RV_XLEN-1:0] data_wdata,
	output logic                data_ack,
	output logic                data_resp,
	output logic [`RV_XLEN-1:0] data_rdata,
	output logic                mem_req,
	output logic [4:0]          mem_rqtype,
	output logic [2:0]          mem_size,
	output logic [`RV_XLEN-1:0] mem_addr,
	output logic [`RV_XLEN-1:0] mem_wdata,
	input  wire                 mem_req_ack,
	input  wire                 mem_resp,
	input  wire  [`RV_XLEN-1:0] mem_resp_data
);

	arb_state_e state;
	logic       fetch_out;  // Fetch acked, response not back yet

	assign mem_size    = 3'd2;  // Word only
	assign fetch_rdata = mem_resp_data;
	assign data_rdata  = mem_resp_data;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state     <= ARB_INSTR;
			fetch_out <= 1'b0;
		end
		else
		begin
			case (state)
				// Never pull an unacked fetch off the port
				ARB_INSTR: if (data_req && (!fetch_req || mem_req_ack)) state <= ARB_WAIT;
				ARB_WAIT:  if (!fetch_out || mem_resp) state <= ARB_MEM;
				ARB_MEM:   if (mem_resp) state <= ARB_INSTR;
				default:   state <= ARB_INSTR;
			endcase
			if (fetch_resp)
				fetch_out <= 1'b0;
			if (fetch_req && fetch_ack)
				fetch_out <= 1'b1;
		end
	end

	always_comb
	begin
		fetch_ack  = 1'b0;
		fetch_resp = 1'b0;
		data_ack   = 1'b0;
		data_resp  = 1'b0;
		mem_req    = 1'b0;
		mem_rqtype = data_rqtype;
		mem_addr   = data_addr;
		mem_wdata  = data_wdata;
		case (state)
			ARB_INSTR:
			begin
				mem_req    = fetch_req;
				mem_rqtype = `RQ_IFILL;
				mem_addr   = fetch_addr;
				mem_wdata  = '0;
				fetch_ack  = mem_req_ack;
				fetch_resp = mem_resp;
			end
			ARB_WAIT: fetch_resp = mem_resp && fetch_out;  // Drain the last fetch
			ARB_MEM:
			begin
				mem_req   = data_req;
				data_ack  = mem_req_ack;
				data_resp = mem_resp;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/result_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module result_unit (
	input  wire                 clk,
	input  wire                 nrst,
	input  wire  [4:0]          rs1_addr,
	input  wire  [4:0]          rs2_addr,
	output logic [`RV_XLEN-1:0] rs1_data,
	output logic [`RV_XLEN-1:0] rs2_data,
	input  wire                 wb_en,
	input  wire  [4:0]          wb_rd,
	input  wire  [`RV_XLEN-1:0] wb_data
);

	logic [`RV_XLEN-1:0] regs [1:31];  // x0 has no storage

	// x0 reads zero, same-cycle write bypasses the array
	function automatic logic [`RV_XLEN-1:0] read_reg(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		else if (wb_en && wb_rd == addr)
			return wb_data;
		else
			return regs[addr];
	endfunction

	always_comb rs1_data = read_reg(rs1_addr);
	always_comb rs2_data = read_reg(rs2_addr);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_en && wb_rd != 5'd0)  // Writes to x0 ignored
			regs[wb_rd] <= wb_data;
	end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module execute_unit import rv_core_pkg::*; (
	input  wire                 clk,
	input  wire                 nrst,
	input  wire                 issue_valid,
	input  wire  [`RV_XLEN-1:0] op_a,
	input  wire  [`RV_XLEN-1:0] op_b,
	input  wire  [`RV_XLEN-1:0] imm,
	input  wire  [4:0]          rd,
	input  wire                 rd_we,
	input  wire alu_op_e        alu_op,
	input  wire mem_op_e        mem_op,
	input  wire                 is_branch,
	input  wire                 branch_ne,
	input  wire                 is_jal,
	input  wire  [`RV_XLEN-1:0] issue_pc,
	output logic                exec_busy,   // Load or store in progress
	output logic                redirect,
	output logic [`RV_XLEN-1:0] redirect_pc,
	output logic                wb_en,
	output logic [4:0]          wb_rd,
	output logic [`RV_XLEN-1:0] wb_data,
	output logic                data_req,    // Held until data_ack
	output logic [4:0]          data_rqtype,
	output logic [`RV_XLEN-1:0] data_addr,
	output logic [`RV_XLEN-1:0] data_wdata,
	input  wire                 data_ack,
	input  wire                 data_resp,
	input  wire  [`RV_XLEN-1:0] data_rdata
);

	exec_state_e         state;
	logic [`RV_XLEN-1:0] alu_res;
	logic                start;     // Instruction accepted this cycle
	logic                taken;
	logic                is_store;
	logic                load_we;   // Load result goes to a register

	assign start       = issue_valid && state == EX_IDLE;
	assign taken       = is_branch && ((op_a == op_b) != branch_ne);
	assign exec_busy   = state != EX_IDLE;
	assign data_req    = state == EX_REQ;
	assign data_rqtype = is_store ? `RQ_STORE : `RQ_LOAD;

	always_comb
	begin
		case (alu_op)
			ALU_ADD:    alu_res = op_a + op_b;
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_OR:     alu_res = op_a | op_b;
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state    <= EX_IDLE;
			wb_en    <= 1'b0;
			redirect <= 1'b0;
		end
		else
		begin
			wb_en    <= 1'b0;  // Both are single-cycle pulses
			redirect <= 1'b0;
			case (state)
				EX_IDLE:
					if (issue_valid)
					begin
						if (mem_op != MEM_NONE)
							state <= EX_REQ;
						else
						begin
							wb_en    <= rd_we;           // ALU and JAL done next cycle
							redirect <= taken || is_jal;
						end
					end
				EX_REQ:
					if (data_ack)
						state <= EX_RESP;
				EX_RESP:
					if (data_resp)  // Store also gets one response
					begin
						state <= EX_IDLE;
						wb_en <= load_we;
					end
				default: state <= EX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			wb_rd       <= rd;
			wb_data     <= is_jal ? issue_pc + 32'd4 : alu_res;  // JAL links pc+4
			redirect_pc <= issue_pc + imm;  // B or J immediate
			data_addr   <= op_a + imm;
			data_wdata  <= op_b;
			is_store    <= mem_op == MEM_STORE;
			load_we     <= mem_op == MEM_LOAD && rd_we;
		end
		if (state == EX_RESP && data_resp)
			wb_data <= data_rdata;
	end

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module decode_unit import rv_core_pkg::*; (
	input  wire                 clk,
	input  wire                 nrst,
	input  wire                 fetch_valid,
	input  wire  [`RV_XLEN-1:0] instr,
	input  wire  [`RV_XLEN-1:0] instr_pc,
	output logic                fetch_take,
	input  wire                 exec_busy,
	input  wire                 redirect,
	output logic [4:0]          rs1_addr,
	output logic [4:0]          rs2_addr,
	input  wire  [`RV_XLEN-1:0] rs1_data,
	input  wire  [`RV_XLEN-1:0] rs2_data,
	output logic                issue_valid,  // One-cycle pulse
	output logic [`RV_XLEN-1:0] op_a,
	output logic [`RV_XLEN-1:0] op_b,
	output logic [`RV_XLEN-1:0] imm,
	output logic [4:0]          rd,
	output logic                rd_we,
	output alu_op_e             alu_op,
	output mem_op_e             mem_op,
	output logic                is_branch,
	output logic                branch_ne,
	output logic                is_jal,
	output logic [`RV_XLEN-1:0] issue_pc
);

	opcode_e             opcode;
	logic [2:0]          funct3;
	logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [`RV_XLEN-1:0] d_imm;
	logic                d_use_imm;  // op_b from immediate, else rs2
	logic                d_we;
	logic                d_br;
	logic                d_jal;
	alu_op_e             d_alu;
	alu_op_e             funct_alu;
	mem_op_e             d_mem;

	assign opcode   = opcode_e'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign rs1_addr = instr[19:15];  // Register file read, same cycle as take
	assign rs2_addr = instr[24:20];

	// Sign-extended immediates, all formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// One instruction in flight, wrong-path word dropped on redirect
	assign fetch_take = fetch_valid && !exec_busy && !issue_valid && !redirect;

	always_comb
	begin
		case (funct3)
			3'b000:  funct_alu = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
			3'b010:  funct_alu = ALU_SLT;
			3'b100:  funct_alu = ALU_XOR;
			3'b110:  funct_alu = ALU_OR;
			3'b111:  funct_alu = ALU_AND;
			default: funct_alu = ALU_ADD;  // Shifts etc. not in subset
		endcase
	end

	always_comb
	begin
		d_imm     = imm_i;
		d_use_imm = 1'b1;
		d_we      = 1'b0;
		d_alu     = ALU_ADD;
		d_mem     = MEM_NONE;
		d_br      = 1'b0;
		d_jal     = 1'b0;
		case (opcode)
			OPC_OP:
			begin
				d_use_imm = 1'b0;
				d_we      = 1'b1;
				d_alu     = funct_alu;
			end
			OPC_OP_IMM:
			begin
				d_we  = 1'b1;
				d_alu = funct_alu;
			end
			OPC_LUI:
			begin
				d_imm = imm_u;
				d_we  = 1'b1;
				d_alu = ALU_PASS_B;
			end
			OPC_LOAD:
			begin
				d_we  = 1'b1;
				d_mem = MEM_LOAD;
			end
			OPC_STORE:
			begin
				d_imm     = imm_s;
				d_use_imm = 1'b0;  // rs2 carries the store data
				d_mem     = MEM_STORE;
			end
			OPC_BRANCH:
			begin
				d_imm     = imm_b;
				d_use_imm = 1'b0;
				d_br      = 1'b1;
			end
			OPC_JAL:
			begin
				d_imm = imm_j;
				d_we  = 1'b1;
				d_jal = 1'b1;
			end
			default: ;  // Unknown, issued as no-op
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			issue_valid <= 1'b0;
		else
			issue_valid <= fetch_take;
	end

	// Issue register
	always_ff @(posedge clk)
	begin
		if (fetch_take)
		begin
			op_a      <= rs1_data;
			op_b      <= d_use_imm ? d_imm : rs2_data;
			imm       <= d_imm;
			rd        <= instr[11:7];
			rd_we     <= d_we;
			alu_op    <= d_alu;
			mem_op    <= d_mem;
			is_branch <= d_br;
			branch_ne <= funct3[0];  // BEQ 000, BNE 001
			is_jal    <= d_jal;
			issue_pc  <= instr_pc;
		end
	end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_macros.svh"

module fetch_unit (
	input  wire                 clk,
	input  wire                 nrst,
	input  wire                 redirect,    // Taken branch or JAL
	input  wire  [`RV_XLEN-1:0] redirect_pc,
	input  wire                 fetch_take,  // Decode pops the buffer
	output logic                fetch_req,
	output logic [`RV_XLEN-1:0] fetch_addr,
	input  wire                 fetch_ack,
	input  wire                 fetch_resp,
	input  wire  [`RV_XLEN-1:0] fetch_rdata,
	output logic                fetch_valid,
	output logic [`RV_XLEN-1:0] instr,       // Buffered word
	output logic [`RV_XLEN-1:0] instr_pc
);

	logic [`RV_XLEN-1:0] pc;          // Address of the next request
	logic [`RV_XLEN-1:0] out_pc;      // Address of the word in flight
	logic [`RV_XLEN-1:0] redir_pc_q;  // Target parked behind an unacked request
	logic                run;         // Keeps the port quiet for one cycle out of reset
	logic                buf_valid;
	logic                out_valid;   // Acked, response still to come
	logic                drop;        // Response in flight is wrong path
	logic                req_hold;    // Request was up last cycle without ack
	logic                redir_pend;
	logic                buf_free;

	// Buffer empty now or emptied by decode this cycle
	assign buf_free    = !buf_valid || fetch_take;
	// Once raised, request stays until acked
	assign fetch_req   = req_hold || (run && !out_valid && buf_free && !redirect && !redir_pend);
	assign fetch_addr  = pc;
	assign fetch_valid = buf_valid;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			pc         <= `RV_RESET_PC;
			run        <= 1'b0;
			buf_valid  <= 1'b0;
			out_valid  <= 1'b0;
			drop       <= 1'b0;
			req_hold   <= 1'b0;
			redir_pend <= 1'b0;
		end
		else
		begin
			run      <= 1'b1;
			req_hold <= fetch_req && !fetch_ack;
			if (fetch_take)
				buf_valid <= 1'b0;
			if (fetch_resp && out_valid)
			begin
				out_valid <= 1'b0;
				drop      <= 1'b0;
				if (!drop && !redirect)  // Stale words never reach decode
					buf_valid <= 1'b1;
			end
			if (fetch_req && fetch_ack)
			begin
				out_valid  <= 1'b1;
				drop       <= redirect || redir_pend;  // Old-path word, discard on return
				redir_pend <= 1'b0;
				pc         <= redir_pend ? redir_pc_q : pc + 32'd4;
			end
			if (redirect)
			begin
				buf_valid <= 1'b0;
				// Address must hold until ack, so park the target
				if (fetch_req && !fetch_ack)
					redir_pend <= 1'b1;
				else
					pc <= redirect_pc;
				if (out_valid && !fetch_resp)
					drop <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch_resp && out_valid)
		begin
			instr    <= fetch_rdata;
			instr_pc <= out_pc;
		end
		if (fetch_req && fetch_ack)
			out_pc <= pc;
		if (redirect && fetch_req && !fetch_ack)
			redir_pc_q <= redirect_pc;
	end

endmodule

`default_nettype wire

//--- hw/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B  // LUI, immediate straight through
	} alu_op_e;

	typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

	// Port owner, same three states as the L1.5 arbiter
	typedef enum logic [1:0] {ARB_INSTR, ARB_WAIT, ARB_MEM} arb_state_e;

	typedef enum logic [1:0] {EX_IDLE, EX_REQ, EX_RESP} exec_state_e;

endpackage

`default_nettype wire

//--- hw/rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Datapath and address width
`define RV_XLEN 32

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// Request types on mem_rqtype, L1.5 encoding
`define RQ_LOAD  5'b00000
`define RQ_STORE 5'b00001
`define RQ_IFILL 5'b10000

`endif
